/* steer_pkg.sv */
// shared localparams, command and state enums, pixel, result and motor frame types
package steer_pkg;

    // frame geometry
    localparam int FRAME_W          = 8;
    localparam int FRAME_H          = 8;
    localparam int PIXELS_PER_FRAME = FRAME_W * FRAME_H;
    localparam int HALF_W           = 4;
    localparam int COL_W            = $clog2(FRAME_W);
    localparam int PIX_CNT_W        = $clog2(PIXELS_PER_FRAME);

    // motor link
    localparam int          SPI_TX_DIV   = 4;
    localparam int          TX_DIV_W     = $clog2(SPI_TX_DIV);
    localparam int          TX_BITS      = 32;
    localparam int          TX_BIT_W     = $clog2(TX_BITS);
    localparam logic [23:0] MOTOR_HEADER = 24'h00AA55;

    localparam int RESULT_W = 48;

    typedef enum logic [2:0] {
        CMD_STOP  = 3'd0,
        CMD_RIGHT = 3'd1,
        CMD_LEFT  = 3'd2
    } motor_cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_RECEIVING  = 3'd1,
        ST_PROCESSING = 3'd2,
        ST_SENDING    = 3'd3,
        ST_DONE       = 3'd4
    } ctrl_state_e;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } pixel_beat_t;

    typedef struct packed {
        logic [23:0] header;
        logic [4:0]  reserved;
        motor_cmd_e  cmd;
    } motor_fields_t;

    // raw word for the shifter, fields for building and decoding
    typedef union packed {
        logic [TX_BITS-1:0] raw;
        motor_fields_t      fields;
    } motor_frame_u;

    typedef struct packed {
        logic                       valid;
        logic signed [RESULT_W-1:0] value;
    } feature_res_t;

endpackage

/* spi_pixel_rx.sv */
// SPI mode-0 pixel slave with host line synchronizers and command status on MISO
`timescale 1ns/1ps

module spi_pixel_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sclk_i,
    input  logic                   mosi_i,
    input  logic                   ss_i,
    output logic                   miso_o,
    input  steer_pkg::motor_cmd_e  last_cmd_i,
    output steer_pkg::pixel_beat_t pix_o
);

    // two sync stages plus one delay stage for edge detect
    logic [2:0] sclk_sync;
    logic [2:0] ss_sync;
    logic [1:0] mosi_sync;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_fall;
    logic       ss_active;
    logic [2:0] bit_cnt_q;
    logic [6:0] rx_sh_q;
    logic [7:0] tx_sh_q;
    logic       pix_valid_q;
    logic [7:0] pix_data_q;

    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign ss_fall   = ~ss_sync[1] & ss_sync[2];
    assign ss_active = ~ss_sync[1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync   <= '0;
            ss_sync     <= '1;
            mosi_sync   <= '0;
            bit_cnt_q   <= '0;
            tx_sh_q     <= '0;
            pix_valid_q <= 1'b0;
        end else begin
            sclk_sync   <= {sclk_sync[1:0], sclk_i};
            ss_sync     <= {ss_sync[1:0], ss_i};
            mosi_sync   <= {mosi_sync[0], mosi_i};
            pix_valid_q <= 1'b0;
            if (!ss_active) begin
                bit_cnt_q <= '0;
            end else if (sclk_rise) begin
                bit_cnt_q   <= bit_cnt_q + 1'b1;
                pix_valid_q <= (bit_cnt_q == 3'd7);
            end
            // status byte shifts out MSB first on falling sclk
            if (ss_fall) begin
                tx_sh_q <= {5'b0, last_cmd_i};
            end else if (ss_active && sclk_fall) begin
                tx_sh_q <= {tx_sh_q[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ss_active && sclk_rise) begin
            rx_sh_q <= {rx_sh_q[5:0], mosi_sync[1]};
            if (bit_cnt_q == 3'd7) begin
                pix_data_q <= {rx_sh_q, mosi_sync[1]};
            end
        end
    end

    assign miso_o = tx_sh_q[7];
    assign pix_o  = '{valid: pix_valid_q, data: pix_data_q};

    a_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) pix_o.valid |=> !pix_o.valid
    );

endmodule

/* steer_feature_accum.sv */
// column-weighted signed feature accumulator over one frame
`timescale 1ns/1ps

module steer_feature_accum (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  steer_pkg::pixel_beat_t  pix_i,
    output logic                    busy_o,
    output steer_pkg::feature_res_t res_o
);

    logic [steer_pkg::COL_W-1:0]          col_q;
    logic [steer_pkg::COL_W-1:0]          col_cur;
    logic [steer_pkg::PIX_CNT_W-1:0]      cnt_q;
    logic [steer_pkg::PIX_CNT_W-1:0]      cnt_cur;
    logic signed [steer_pkg::RESULT_W-1:0] acc_q;
    logic signed [steer_pkg::RESULT_W-1:0] acc_nxt;
    logic signed [steer_pkg::RESULT_W-1:0] pix_ext;
    logic signed [steer_pkg::RESULT_W-1:0] term;
    logic                                 busy_q;
    logic                                 res_valid_q;
    logic                                 take;
    logic                                 last;

    assign take = pix_i.valid && (start_i || busy_q);

    // start restarts column, count and sum with this beat
    always_comb begin
        col_cur = start_i ? '0 : col_q;
        cnt_cur = start_i ? '0 : cnt_q;
        pix_ext = steer_pkg::RESULT_W'(pix_i.data);
        term    = (col_cur < steer_pkg::COL_W'(steer_pkg::HALF_W)) ? -pix_ext : pix_ext;
        acc_nxt = (start_i ? '0 : acc_q) + term;
        last    = (cnt_cur == steer_pkg::PIX_CNT_W'(steer_pkg::PIXELS_PER_FRAME - 1));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q       <= '0;
            cnt_q       <= '0;
            busy_q      <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= take && last;
            if (take) begin
                if (col_cur == steer_pkg::COL_W'(steer_pkg::FRAME_W - 1)) begin
                    col_q <= '0;
                end else begin
                    col_q <= col_cur + 1'b1;
                end
                cnt_q  <= cnt_cur + 1'b1;
                busy_q <= !last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            acc_q <= acc_nxt;
        end
    end

    assign busy_o = busy_q;
    assign res_o  = '{valid: res_valid_q, value: acc_q};

    a_start_with_beat: assert property (
        @(posedge clk) disable iff (!rst_n) start_i |-> pix_i.valid
    );

    a_no_stray_beat: assert property (
        @(posedge clk) disable iff (!rst_n) (pix_i.valid && !busy_q) |-> start_i
    );

endmodule

/* frame_ctrl.sv */
// frame FSM with pixel forwarding, command classification, motor frame build and LEDs
`timescale 1ns/1ps

module frame_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  steer_pkg::pixel_beat_t  pix_i,
    output logic                    feat_start_o,
    output steer_pkg::pixel_beat_t  feat_pix_o,
    input  logic                    feat_busy_i,
    input  steer_pkg::feature_res_t feat_res_i,
    output steer_pkg::motor_frame_u tx_frame_o,
    output logic                    tx_valid_o,
    input  logic                    tx_ready_i,
    output steer_pkg::motor_cmd_e   last_cmd_o,
    output logic [3:0]              status_led_o
);

    steer_pkg::ctrl_state_e          state_q;
    steer_pkg::ctrl_state_e          state_d;
    steer_pkg::motor_cmd_e           cmd_q;
    steer_pkg::motor_cmd_e           last_cmd_q;
    logic [steer_pkg::PIX_CNT_W-1:0] pix_cnt_q;
    logic [7:0]                      fwd_data_q;
    logic                            fwd_valid_q;
    logic                            start_q;
    logic                            tx_valid_q;
    logic                            sent_q;
    logic                            take;
    logic                            last_pix;
    logic                            handshake;

    // pixels only enter while idle or receiving
    assign take = pix_i.valid &&
                  (state_q == steer_pkg::ST_IDLE || state_q == steer_pkg::ST_RECEIVING);
    assign last_pix  = (pix_cnt_q == steer_pkg::PIX_CNT_W'(steer_pkg::PIXELS_PER_FRAME - 1));
    assign handshake = tx_valid_q && tx_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            steer_pkg::ST_IDLE:       if (take) state_d = steer_pkg::ST_RECEIVING;
            steer_pkg::ST_RECEIVING:  if (take && last_pix) state_d = steer_pkg::ST_PROCESSING;
            steer_pkg::ST_PROCESSING: if (feat_res_i.valid) state_d = steer_pkg::ST_SENDING;
            // wait until the master has shifted the frame out
            steer_pkg::ST_SENDING:    if (sent_q && tx_ready_i) state_d = steer_pkg::ST_DONE;
            default:                  state_d = steer_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= steer_pkg::ST_IDLE;
            pix_cnt_q   <= '0;
            fwd_valid_q <= 1'b0;
            start_q     <= 1'b0;
            cmd_q       <= steer_pkg::CMD_STOP;
            last_cmd_q  <= steer_pkg::CMD_STOP;
            tx_valid_q  <= 1'b0;
            sent_q      <= 1'b0;
        end else begin
            state_q     <= state_d;
            fwd_valid_q <= take;
            start_q     <= take && (pix_cnt_q == '0);
            if (take) begin
                pix_cnt_q <= pix_cnt_q + 1'b1;
            end else if (state_q == steer_pkg::ST_DONE) begin
                pix_cnt_q <= '0;
            end
            if (state_q == steer_pkg::ST_PROCESSING && feat_res_i.valid) begin
                if (feat_res_i.value[steer_pkg::RESULT_W-1]) begin
                    cmd_q <= steer_pkg::CMD_LEFT;
                end else if (|feat_res_i.value) begin
                    cmd_q <= steer_pkg::CMD_RIGHT;
                end else begin
                    cmd_q <= steer_pkg::CMD_STOP;
                end
                tx_valid_q <= 1'b1;
            end else if (handshake) begin
                tx_valid_q <= 1'b0;
            end
            if (handshake) begin
                sent_q     <= 1'b1;
                last_cmd_q <= cmd_q;
            end else if (state_q == steer_pkg::ST_DONE) begin
                sent_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            fwd_data_q <= pix_i.data;
        end
    end

    always_comb begin
        tx_frame_o.fields = '{header: steer_pkg::MOTOR_HEADER, reserved: '0, cmd: cmd_q};
    end

    always_comb begin
        case (state_q)
            steer_pkg::ST_IDLE:       status_led_o = 4'b0001;
            steer_pkg::ST_RECEIVING:  status_led_o = 4'b0010;
            steer_pkg::ST_PROCESSING: status_led_o = 4'b0100;
            steer_pkg::ST_SENDING:    status_led_o = 4'b1000;
            default:                  status_led_o = 4'b1111;
        endcase
    end

    assign feat_start_o = start_q;
    assign feat_pix_o   = '{valid: fwd_valid_q, data: fwd_data_q};
    assign tx_valid_o   = tx_valid_q;
    assign last_cmd_o   = last_cmd_q;

    a_engine_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q == steer_pkg::ST_PROCESSING && !feat_res_i.valid) |-> feat_busy_i
    );

endmodule

/* spi_motor_tx.sv */
// SPI mode-0 master that shifts one 32-bit motor frame
`timescale 1ns/1ps

module spi_motor_tx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  steer_pkg::motor_frame_u frame_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    output logic                    sclk_o,
    output logic                    mosi_o,
    input  logic                    miso_i,
    output logic                    ss_o
);

    logic [steer_pkg::TX_DIV_W-1:0] div_q;
    logic [steer_pkg::TX_BIT_W-1:0] bit_q;
    logic [steer_pkg::TX_BITS-1:0]  sh_q;
    // motor board reply held for later reply checking
    logic [7:0]                     ack_q;
    logic                           active_q;
    logic                           close_q;
    logic                           gap_q;
    logic                           sclk_q;
    logic                           mosi_q;
    logic                           ss_q;
    logic                           accept;
    logic                           rise_tick;
    logic                           fall_tick;
    logic                           last_bit;

    assign ready_o   = ~(active_q | close_q | gap_q);
    assign accept    = valid_i && ready_o;
    assign rise_tick = active_q &&
                       (div_q == steer_pkg::TX_DIV_W'(steer_pkg::SPI_TX_DIV / 2 - 1));
    assign fall_tick = active_q && (div_q == steer_pkg::TX_DIV_W'(steer_pkg::SPI_TX_DIV - 1));
    assign last_bit  = (bit_q == steer_pkg::TX_BIT_W'(steer_pkg::TX_BITS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            close_q  <= 1'b0;
            gap_q    <= 1'b0;
            div_q    <= '0;
            bit_q    <= '0;
            sclk_q   <= 1'b0;
            mosi_q   <= 1'b0;
            ss_q     <= 1'b1;
        end else begin
            close_q <= 1'b0;
            gap_q   <= close_q;
            if (accept) begin
                active_q <= 1'b1;
                ss_q     <= 1'b0;
                mosi_q   <= frame_i.raw[steer_pkg::TX_BITS-1];
                div_q    <= '0;
                bit_q    <= '0;
            end else if (active_q) begin
                div_q <= fall_tick ? '0 : div_q + 1'b1;
                if (rise_tick) begin
                    sclk_q <= 1'b1;
                end
                // mosi moves on the falling edge
                if (fall_tick) begin
                    sclk_q <= 1'b0;
                    if (last_bit) begin
                        active_q <= 1'b0;
                        close_q  <= 1'b1;
                        mosi_q   <= 1'b0;
                    end else begin
                        bit_q  <= bit_q + 1'b1;
                        mosi_q <= sh_q[steer_pkg::TX_BITS-1];
                    end
                end
            end else if (close_q) begin
                ss_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sh_q <= {frame_i.raw[steer_pkg::TX_BITS-2:0], 1'b0};
        end else if (fall_tick && !last_bit) begin
            sh_q <= {sh_q[steer_pkg::TX_BITS-2:0], 1'b0};
        end
        if (rise_tick) begin
            ack_q <= {ack_q[6:0], miso_i};
        end
    end

    assign sclk_o = sclk_q;
    assign mosi_o = mosi_q;
    assign ss_o   = ss_q;

endmodule

/* steer_top.sv */
// pin-level top with pixel slave, feature engine, frame FSM and motor master
`timescale 1ns/1ps

module steer_top (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       spi_slave_sclk_i,
    input  logic       spi_slave_mosi_i,
    input  logic       spi_slave_ss_i,
    output logic       spi_slave_miso_o,
    output logic       spi_master_sclk_o,
    output logic       spi_master_mosi_o,
    input  logic       spi_master_miso_i,
    output logic       spi_master_ss_o,
    output logic [3:0] status_led_o
);

    steer_pkg::pixel_beat_t  rx_pix;
    steer_pkg::pixel_beat_t  feat_pix;
    steer_pkg::feature_res_t feat_res;
    steer_pkg::motor_frame_u tx_frame;
    steer_pkg::motor_cmd_e   last_cmd;
    logic                    feat_start;
    logic                    feat_busy;
    logic                    tx_valid;
    logic                    tx_ready;

    spi_pixel_rx u_pixel_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .sclk_i     (spi_slave_sclk_i),
        .mosi_i     (spi_slave_mosi_i),
        .ss_i       (spi_slave_ss_i),
        .miso_o     (spi_slave_miso_o),
        .last_cmd_i (last_cmd),
        .pix_o      (rx_pix)
    );

    steer_feature_accum u_feature (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (feat_start),
        .pix_i   (feat_pix),
        .busy_o  (feat_busy),
        .res_o   (feat_res)
    );

    frame_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_i        (rx_pix),
        .feat_start_o (feat_start),
        .feat_pix_o   (feat_pix),
        .feat_busy_i  (feat_busy),
        .feat_res_i   (feat_res),
        .tx_frame_o   (tx_frame),
        .tx_valid_o   (tx_valid),
        .tx_ready_i   (tx_ready),
        .last_cmd_o   (last_cmd),
        .status_led_o (status_led_o)
    );

    spi_motor_tx u_motor_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .frame_i (tx_frame),
        .valid_i (tx_valid),
        .ready_o (tx_ready),
        .sclk_o  (spi_master_sclk_o),
        .mosi_o  (spi_master_mosi_o),
        .miso_i  (spi_master_miso_i),
        .ss_o    (spi_master_ss_o)
    );

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 4 ns clock period
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* tb_steer_top.sv */
// testbench with SPI host and motor board models, frame table, compare tasks and timeout
`timescale 1ns/1ps

module tb_steer_top;

    localparam int          N_FRAMES       = 7;
    localparam int          DRIVE_DLY      = 1;
    localparam int          TIMEOUT_CYCLES = N_FRAMES * 64 * 8 * 4 + N_FRAMES * 200 + 500;
    localparam logic [23:0] EXP_HEADER     = 24'h00AA55;

    typedef enum logic [1:0] {
        PAT_LEFT,
        PAT_RIGHT,
        PAT_UNIFORM,
        PAT_RANDOM
    } pattern_e;

    typedef struct packed {
        pattern_e              kind;
        steer_pkg::motor_cmd_e cmd;
    } frame_vec_t;

    logic                    clk;
    logic                    rst_n;
    logic                    slave_sclk;
    logic                    slave_mosi;
    logic                    slave_ss;
    logic                    slave_miso;
    logic                    master_sclk;
    logic                    master_mosi;
    logic                    master_miso;
    logic                    master_ss;
    logic [3:0]              status_led;
    logic [7:0]              pix_mem [64];
    frame_vec_t              vec_table [N_FRAMES];
    integer                  seed;
    int                      errors = 0;
    int                      checks = 0;
    int                      cycle_cnt = 0;
    logic [31:0]             mb_shift;
    int                      mb_rises = 0;
    int                      mb_last_rises = 0;
    int                      mb_frames = 0;
    steer_pkg::motor_frame_u mb_word;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    steer_top steer_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .spi_slave_sclk_i  (slave_sclk),
        .spi_slave_mosi_i  (slave_mosi),
        .spi_slave_ss_i    (slave_ss),
        .spi_slave_miso_o  (slave_miso),
        .spi_master_sclk_o (master_sclk),
        .spi_master_mosi_o (master_mosi),
        .spi_master_miso_i (master_miso),
        .spi_master_ss_o   (master_ss),
        .status_led_o      (status_led)
    );

    // motor board samples mosi on rising sclk while selected
    always @(posedge master_sclk) begin
        if (rst_n === 1'b1 && master_ss === 1'b0) begin
            mb_shift = {mb_shift[30:0], master_mosi};
            mb_rises = mb_rises + 1;
            check_led(status_led, 4'b1000, "led during motor transfer");
        end
    end

    always @(posedge master_ss) begin
        if (rst_n === 1'b1) begin
            mb_word.raw   = mb_shift;
            mb_last_rises = mb_rises;
            mb_rises      = 0;
            mb_frames     = mb_frames + 1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles before all frames were checked",
                     cycle_cnt);
            errors = errors + 1;
            finish_run();
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_cmd(input steer_pkg::motor_cmd_e got, input steer_pkg::motor_cmd_e exp,
                             input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %0d expected %0d", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_frame(input steer_pkg::motor_frame_u got,
                               input steer_pkg::motor_frame_u exp, input string what);
        checks = checks + 1;
        if (got.fields.header !== exp.fields.header) begin
            $display("FAIL @%0t: %s header got %h expected %h", $time, what,
                     got.fields.header, exp.fields.header);
            errors = errors + 1;
        end
        if (got.fields.reserved !== exp.fields.reserved) begin
            $display("FAIL @%0t: %s reserved got %b expected %b", $time, what,
                     got.fields.reserved, exp.fields.reserved);
            errors = errors + 1;
        end
        if (got.fields.cmd !== exp.fields.cmd) begin
            $display("FAIL @%0t: %s cmd got %0d expected %0d", $time, what,
                     got.fields.cmd, exp.fields.cmd);
            errors = errors + 1;
        end
    endtask

    task automatic check_led(input logic [3:0] got, input logic [3:0] exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_pin(input logic got, input logic exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            $display("FAIL @%0t: %s got %b expected %b", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic check_value(input int got, input int exp, input string what);
        checks = checks + 1;
        if (got != exp) begin
            $display("FAIL @%0t: %s got %0d expected %0d", $time, what, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic load_table();
        vec_table[0] = '{kind: PAT_RIGHT,   cmd: steer_pkg::CMD_RIGHT};
        vec_table[1] = '{kind: PAT_LEFT,    cmd: steer_pkg::CMD_LEFT};
        vec_table[2] = '{kind: PAT_UNIFORM, cmd: steer_pkg::CMD_STOP};
        // random entries take their command from the drawn pixels
        vec_table[3] = '{kind: PAT_RANDOM,  cmd: steer_pkg::CMD_STOP};
        vec_table[4] = '{kind: PAT_RANDOM,  cmd: steer_pkg::CMD_STOP};
        vec_table[5] = '{kind: PAT_LEFT,    cmd: steer_pkg::CMD_LEFT};
        vec_table[6] = '{kind: PAT_RANDOM,  cmd: steer_pkg::CMD_STOP};
    endtask

    task automatic fill_frame(input pattern_e kind);
        int p;
        for (p = 0; p < 64; p++) begin
            case (kind)
                PAT_LEFT:    pix_mem[p] = (p % 8 < 4) ? (8'hc0 | 8'(p)) : 8'(p);
                PAT_RIGHT:   pix_mem[p] = (p % 8 < 4) ? 8'(p) : (8'hc0 | 8'(p));
                // columns c and c+4 carry the same value
                PAT_UNIFORM: pix_mem[p] = 8'h20 + 8'((p / 8) * 4 + p % 4);
                default:     pix_mem[p] = 8'($random(seed));
            endcase
        end
    endtask

    // columns 0..3 count negative and 4..7 positive
    function automatic steer_pkg::motor_cmd_e weighted_cmd();
        int sum;
        int p;
        sum = 0;
        for (p = 0; p < 64; p++) begin
            if (p % 8 < 4) begin
                sum = sum - int'(pix_mem[p]);
            end else begin
                sum = sum + int'(pix_mem[p]);
            end
        end
        if (sum > 0) begin
            return steer_pkg::CMD_RIGHT;
        end else if (sum < 0) begin
            return steer_pkg::CMD_LEFT;
        end
        return steer_pkg::CMD_STOP;
    endfunction

    // mode 0 byte with 16 ns sclk and miso sampled at the end of the high phase
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            slave_mosi = tx[i];
            wait_cycles(2);
            slave_sclk = 1'b1;
            wait_cycles(2);
            rx[i]      = slave_miso;
            slave_sclk = 1'b0;
        end
    endtask

    task automatic send_frame(output logic [7:0] first_rx);
        logic [7:0] rx;
        int         p;
        wait_cycles(1);
        slave_ss = 1'b0;
        // slave loads its status byte after the synchronized ss edge
        wait_cycles(4);
        for (p = 0; p < 64; p++) begin
            shift_byte(pix_mem[p], rx);
            if (p == 0) begin
                first_rx = rx;
            end
        end
        wait_cycles(1);
        slave_ss = 1'b1;
        wait_cycles(2);
    endtask

    initial begin
        steer_pkg::motor_cmd_e   prev_cmd;
        steer_pkg::motor_cmd_e   exp_cmd;
        steer_pkg::motor_frame_u exp_frame;
        logic [7:0]              status;
        int                      f;
        seed        = 32'hbe83_f193;
        slave_sclk  = 1'b0;
        slave_mosi  = 1'b0;
        slave_ss    = 1'b1;
        master_miso = 1'b0;
        prev_cmd    = steer_pkg::CMD_STOP;
        load_table();
        wait (rst_n === 1'b1);
        wait_cycles(1);
        check_led(status_led, 4'b0001, "led after reset");
        check_pin(master_ss, 1'b1, "motor ss after reset");
        check_pin(master_sclk, 1'b0, "motor sclk after reset");
        for (f = 0; f < N_FRAMES; f++) begin
            fill_frame(vec_table[f].kind);
            exp_cmd = weighted_cmd();
            if (vec_table[f].kind != PAT_RANDOM && vec_table[f].cmd != exp_cmd) begin
                $display("table entry %0d does not agree with the weighting of its pixels", f);
                errors = errors + 1;
            end
            send_frame(status);
            // first byte back carries the previous frame's command
            check_cmd(steer_pkg::motor_cmd_e'(status[2:0]), prev_cmd, "status byte command");
            check_value(int'(status[7:3]), 0, "status byte padding");
            while (mb_frames < f + 1) begin
                wait_cycles(1);
            end
            exp_frame.fields = '{header: EXP_HEADER, reserved: 5'b0, cmd: exp_cmd};
            check_frame(mb_word, exp_frame, "motor frame");
            check_value(mb_last_rises, 32, "sclk rises while ss low");
            while (status_led !== 4'b0001) begin
                wait_cycles(1);
            end
            check_value(mb_frames, f + 1, "motor frames sent");
            prev_cmd = exp_cmd;
        end
        finish_run();
    end

endmodule

/* all.f */
steer_pkg.sv
spi_pixel_rx.sv
steer_feature_accum.sv
frame_ctrl.sv
spi_motor_tx.sv
steer_top.sv
tb_clk_gen.sv
tb_steer_top.sv

/* Bender.yml */
package:
  name: steer_ctrl

sources:
  - steer_pkg.sv
  - spi_pixel_rx.sv
  - steer_feature_accum.sv
  - frame_ctrl.sv
  - spi_motor_tx.sv
  - steer_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_steer_top.sv
